/* include/vlane_seq_cfg.svh */
// Sequencer configuration values
// Lane count, register file depth, vector length limit and field widths

`ifndef VLANE_SEQ_CFG_SVH
`define VLANE_SEQ_CFG_SVH

// Lanes in the vector unit
`define VLANE_NUM 8

// Words per lane in the vector register file
`define MEM_DEPTH 512

// Largest element count held by one lane
`define MAX_VL_PER_LANE 256

`define R_PORTS_NUM 8      // Read ports seen by the store and index muxes
`define ALU_OPMODE_W 6     // ALU opmode field

// Read address counters, vs1 vs2 vs3
`define RD_PORTS 3

`endif

/* hw/vlane_seq_pkg.sv */
// Shared types of the lane sequencer
// Vector widths, instruction and state enums, command and write structs

`include "vlane_seq_cfg.svh"

package vlane_seq_pkg;

    ////////////////////////////////////////
    // Plain vector widths
    typedef logic [$clog2(`MEM_DEPTH)-1:0]                     vrf_addr_t;
    typedef logic [$clog2(`VLANE_NUM * `MAX_VL_PER_LANE)-1:0]  vl_t;
    typedef logic [$clog2(`MAX_VL_PER_LANE):0]                 step_t;     // Counts up to the max
    typedef logic [`VLANE_NUM-1:0]                             lane_mask_t;
    typedef logic [3:0]                                        bwen_t;
    typedef logic [$clog2(`R_PORTS_NUM)-1:0]                   port_sel_t;

    ////////////////////////////////////////
    // Enums
    typedef enum logic [1:0] {
        EW_BYTE = 2'd1,
        EW_HALF = 2'd2,
        EW_WORD = 2'd3
    } elem_width_e;

    // Codes 1 and 6 belonged to reductions and slides
    typedef enum logic [2:0] {
        NORMAL        = 3'd0,
        STORE         = 3'd2,
        INDEXED_STORE = 3'd3,
        LOAD          = 3'd4,
        INDEXED_LOAD  = 3'd5
    } inst_type_e;

    typedef enum logic [1:0] {S_IDLE, S_EXEC, S_READ, S_LOAD} seq_state_e;

    ////////////////////////////////////////
    // Structs
    typedef struct packed {
        logic [`ALU_OPMODE_W-1:0] opmode;
        logic [31:0]              x_data;
        logic [4:0]               imm;
        logic [1:0]               op2_sel;
        port_sel_t                op3_sel;
        logic                     vector_mask;
        logic                     mul32_en;     // 32-bit multiply
    } alu_ctrl_t;

    typedef struct packed {
        inst_type_e                  inst_type;
        vl_t                         vl;
        step_t                       inst_delay;     // Read to write distance
        elem_width_e                 vsew;
        elem_width_e                 wdata_width;
        vrf_addr_t                   waddr;
        vrf_addr_t [`RD_PORTS-1:0]   raddr;          // vs1, vs2, vs3
        port_sel_t                   store_data_sel;
        port_sel_t                   index_sel;
        alu_ctrl_t                   alu;
    } seq_cmd_t;

    typedef struct packed {
        bwen_t [`VLANE_NUM-1:0] bwen;
        logic                   last;
    } load_beat_t;

    typedef struct packed {
        vrf_addr_t              addr;
        bwen_t [`VLANE_NUM-1:0] bwen;
    } vrf_wr_t;

endpackage

/* hw/vrf_addr_counter.sv */
// Register file address counter
// Steps element by element, advancing the word once the sub-word position wraps
// Byte enable decoded from the sub-word position

`timescale 1ns/10ps

module vrf_addr_counter (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  vlane_seq_pkg::vrf_addr_t    base_i,
    input  vlane_seq_pkg::elem_width_e  width_i,
    input  logic                        load_i,
    input  logic                        step_i,
    output vlane_seq_pkg::vrf_addr_t    addr_o,
    output vlane_seq_pkg::bwen_t        bwen_o
);

    vlane_seq_pkg::vrf_addr_t addr_q;
    logic [1:0]               pos_q;       // Element inside the current word
    logic [1:0]               last_pos;
    logic                     wrap;

    // Highest position per width
    always_comb begin
        case (width_i)
            vlane_seq_pkg::EW_BYTE: last_pos = 2'd3;
            vlane_seq_pkg::EW_HALF: last_pos = 2'd1;
            default:                last_pos = 2'd0;
        endcase
    end

    assign wrap = (pos_q >= last_pos);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_q <= '0;
            pos_q  <= '0;
        end else if (load_i) begin
            addr_q <= base_i;
            pos_q  <= '0;
        end else if (step_i) begin
            if (wrap) begin
                addr_q <= addr_q + 1'b1;        // Next word
                pos_q  <= '0;
            end else begin
                pos_q  <= pos_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Byte enable decode
    always_comb begin
        case (width_i)
            vlane_seq_pkg::EW_BYTE: bwen_o = 4'b0001 << pos_q;
            vlane_seq_pkg::EW_HALF: bwen_o = pos_q[0] ? 4'b1100 : 4'b0011;
            default:                bwen_o = 4'b1111;
        endcase
    end

    assign addr_o = addr_q;

    // The sequencer reloads only between instructions, never mid-step
    assert property (@(posedge clk_i) disable iff (!rst_i) !(load_i && step_i))
        else $error("address counter loaded and stepped in one cycle");

endmodule

/* hw/lane_valid_tracker.sv */
// Per-lane read valid mask
// Remaining element count, eight elements off per read step

`timescale 1ns/10ps

`include "vlane_seq_cfg.svh"

module lane_valid_tracker (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  vlane_seq_pkg::vl_t          vl_i,
    input  logic                        load_i,
    input  logic                        shift_i,
    output vlane_seq_pkg::lane_mask_t   valid_o
);

    vlane_seq_pkg::vl_t rem_q;      // Elements not yet read

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rem_q <= '0;
        end else if (load_i) begin
            rem_q <= vl_i;
        end else if (shift_i) begin
            if (rem_q > `VLANE_NUM) begin
                rem_q <= rem_q - `VLANE_NUM;
            end else begin
                rem_q <= '0;            // Saturate on the tail row
            end
        end
    end

    ////////////////////////////////////////
    // Lane i valid while i is below the remaining count
    always_comb begin
        for (int i = 0; i < `VLANE_NUM; i++) begin
            valid_o[i] = shift_i && (rem_q > i);
        end
    end

endmodule

/* hw/lane_seq_fsm.sv */
// Instruction sequencer state machine
// Command register, read limit, step counter and mask address counter
// Read, write, store, index and load strobes

`timescale 1ns/10ps

`include "vlane_seq_cfg.svh"

module lane_seq_fsm (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  vlane_seq_pkg::seq_cmd_t     cmd_i,
    input  logic                        cmd_valid_i,
    output logic                        cmd_ready_o,
    input  logic                        load_valid_i,
    input  logic                        load_last_i,
    output logic                        load_ready_o,
    output logic                        rd_load_o,
    output logic                        rd_step_o,
    output logic                        wr_load_o,
    output logic                        wr_step_o,
    output logic                        wr_from_load_o,
    output logic                        valid_load_o,
    output logic                        valid_shift_o,
    output logic                        vrf_ren_o,
    output logic                        vrf_wen_o,
    output vlane_seq_pkg::step_t        vmrf_addr_o,
    output logic                        vmrf_wen_o,
    output logic                        store_data_valid_o,
    output logic                        index_valid_o,
    output vlane_seq_pkg::port_sel_t    store_data_sel_o,
    output vlane_seq_pkg::port_sel_t    index_sel_o,
    output vlane_seq_pkg::alu_ctrl_t    alu_ctrl_o,
    output vlane_seq_pkg::seq_cmd_t     inst_reg_o
);

    vlane_seq_pkg::seq_state_e state_q;
    vlane_seq_pkg::seq_state_e state_d;
    vlane_seq_pkg::seq_cmd_t   inst_q;
    vlane_seq_pkg::step_t      read_limit_q;
    vlane_seq_pkg::step_t      read_limit;
    vlane_seq_pkg::step_t      vmrf_q;
    logic [$bits(vlane_seq_pkg::step_t):0] step_q;      // One bit over, delay plus limit
    logic [$bits(vlane_seq_pkg::step_t):0] last_step;
    logic accept;
    logic step_done;
    logic rd_active;
    logic wr_active;
    logic load_xfer;
    logic is_store;
    logic is_index;

    ////////////////////////////////////////
    // Handshake and read limit
    assign cmd_ready_o = (state_q == vlane_seq_pkg::S_IDLE);
    assign accept      = cmd_valid_i && cmd_ready_o;

    // Rows of eight elements, rounded up
    assign read_limit = vlane_seq_pkg::step_t'((cmd_i.vl >> $clog2(`VLANE_NUM))
                      + (cmd_i.vl[$clog2(`VLANE_NUM)-1:0] != '0));

    // Payload held for the whole instruction
    always_ff @(posedge clk_i) begin
        if (accept) begin
            inst_q       <= cmd_i;
            read_limit_q <= read_limit;
        end
    end

    ////////////////////////////////////////
    // State machine
    assign last_step = (state_q == vlane_seq_pkg::S_EXEC) ?
                       read_limit_q + inst_q.inst_delay - 1'b1 : read_limit_q - 1'b1;
    assign step_done = (step_q == last_step);

    always_comb begin
        state_d = state_q;
        case (state_q)
            vlane_seq_pkg::S_IDLE: begin
                if (accept) begin
                    case (cmd_i.inst_type)
                        vlane_seq_pkg::NORMAL:        state_d = vlane_seq_pkg::S_EXEC;
                        vlane_seq_pkg::STORE,
                        vlane_seq_pkg::INDEXED_STORE,
                        vlane_seq_pkg::INDEXED_LOAD:  state_d = vlane_seq_pkg::S_READ;
                        vlane_seq_pkg::LOAD:          state_d = vlane_seq_pkg::S_LOAD;
                        default:                      state_d = vlane_seq_pkg::S_IDLE;
                    endcase
                end
            end
            vlane_seq_pkg::S_EXEC,
            vlane_seq_pkg::S_READ: begin
                if (step_done) state_d = vlane_seq_pkg::S_IDLE;
            end
            vlane_seq_pkg::S_LOAD: begin
                if (load_xfer && load_last_i) state_d = vlane_seq_pkg::S_IDLE;    // Last beat
            end
            default: state_d = vlane_seq_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= vlane_seq_pkg::S_IDLE;
            step_q  <= '0;
            vmrf_q  <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                step_q <= '0;
                vmrf_q <= '0;
            end else begin
                if (state_q == vlane_seq_pkg::S_EXEC || state_q == vlane_seq_pkg::S_READ) begin
                    step_q <= step_q + 1'b1;
                end
                if (vrf_wen_o) begin
                    vmrf_q <= vmrf_q + 1'b1;    // Mask address counts writes
                end
            end
        end
    end

    ////////////////////////////////////////
    // Strobes
    assign rd_active = (state_q == vlane_seq_pkg::S_EXEC || state_q == vlane_seq_pkg::S_READ)
                    && (step_q < read_limit_q);
    assign wr_active = (state_q == vlane_seq_pkg::S_EXEC) && (step_q >= inst_q.inst_delay);
    assign load_xfer = (state_q == vlane_seq_pkg::S_LOAD) && load_valid_i;

    assign is_store = (inst_q.inst_type == vlane_seq_pkg::STORE)
                   || (inst_q.inst_type == vlane_seq_pkg::INDEXED_STORE);
    assign is_index = (inst_q.inst_type == vlane_seq_pkg::INDEXED_STORE)
                   || (inst_q.inst_type == vlane_seq_pkg::INDEXED_LOAD);

    assign rd_load_o      = accept;     // Counters take their bases on accept
    assign wr_load_o      = accept;
    assign valid_load_o   = accept;
    assign rd_step_o      = rd_active;
    assign valid_shift_o  = rd_active;
    assign vrf_ren_o      = rd_active;
    assign vrf_wen_o      = wr_active || load_xfer;
    assign wr_step_o      = vrf_wen_o;
    assign wr_from_load_o = (state_q == vlane_seq_pkg::S_LOAD);
    assign load_ready_o   = (state_q == vlane_seq_pkg::S_LOAD);

    assign vmrf_addr_o = vmrf_q;
    assign vmrf_wen_o  = vrf_wen_o && inst_q.alu.vector_mask;

    assign store_data_valid_o = rd_active && is_store;
    assign index_valid_o      = rd_active && is_index;
    assign store_data_sel_o   = inst_q.store_data_sel;
    assign index_sel_o        = inst_q.index_sel;
    assign alu_ctrl_o         = inst_q.alu;
    assign inst_reg_o         = inst_q;

    ////////////////////////////////////////
    // Checks
    assert property (@(posedge clk_i) disable iff (!rst_i)
        accept |-> cmd_i.inst_type inside {vlane_seq_pkg::NORMAL, vlane_seq_pkg::STORE,
                                           vlane_seq_pkg::INDEXED_STORE, vlane_seq_pkg::LOAD,
                                           vlane_seq_pkg::INDEXED_LOAD})
        else $error("unsupported instruction type accepted");

    // A normal instruction writes once per read row
    assert property (@(posedge clk_i) disable iff (!rst_i)
        (state_q == vlane_seq_pkg::S_EXEC && step_done) |=> (vmrf_q == read_limit_q))
        else $error("write count differs from the read limit");

endmodule

/* hw/vlane_seq_top.sv */
// Vector lane sequencer top level
// State machine, one write and three read address counters, lane valid tracker

`timescale 1ns/10ps

`include "vlane_seq_cfg.svh"

module vlane_seq_top (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  vlane_seq_pkg::seq_cmd_t                 cmd_i,
    input  logic                                    cmd_valid_i,
    output logic                                    cmd_ready_o,
    input  vlane_seq_pkg::load_beat_t               load_i,
    input  logic                                    load_valid_i,
    output logic                                    load_ready_o,
    output logic                                    vrf_ren_o,
    output vlane_seq_pkg::vrf_addr_t [`RD_PORTS-1:0] vrf_raddr_o,
    output vlane_seq_pkg::vrf_wr_t                  vrf_wr_o,
    output logic                                    vrf_wen_o,
    output vlane_seq_pkg::lane_mask_t               read_data_valid_o,
    output vlane_seq_pkg::step_t                    vmrf_addr_o,
    output logic                                    vmrf_wen_o,
    output logic                                    store_data_valid_o,
    output logic                                    index_valid_o,
    output vlane_seq_pkg::port_sel_t                store_data_sel_o,
    output vlane_seq_pkg::port_sel_t                index_sel_o,
    output vlane_seq_pkg::alu_ctrl_t                alu_ctrl_o
);

    vlane_seq_pkg::seq_cmd_t     inst;
    vlane_seq_pkg::elem_width_e  wr_width;
    vlane_seq_pkg::bwen_t        wr_bwen;
    logic rd_load;
    logic rd_step;
    logic wr_load;
    logic wr_step;
    logic wr_from_load;
    logic valid_load;
    logic valid_shift;

    lane_seq_fsm u_fsm (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .cmd_i              (cmd_i),
        .cmd_valid_i        (cmd_valid_i),
        .cmd_ready_o        (cmd_ready_o),
        .load_valid_i       (load_valid_i),
        .load_last_i        (load_i.last),
        .load_ready_o       (load_ready_o),
        .rd_load_o          (rd_load),
        .rd_step_o          (rd_step),
        .wr_load_o          (wr_load),
        .wr_step_o          (wr_step),
        .wr_from_load_o     (wr_from_load),
        .valid_load_o       (valid_load),
        .valid_shift_o      (valid_shift),
        .vrf_ren_o          (vrf_ren_o),
        .vrf_wen_o          (vrf_wen_o),
        .vmrf_addr_o        (vmrf_addr_o),
        .vmrf_wen_o         (vmrf_wen_o),
        .store_data_valid_o (store_data_valid_o),
        .index_valid_o      (index_valid_o),
        .store_data_sel_o   (store_data_sel_o),
        .index_sel_o        (index_sel_o),
        .alu_ctrl_o         (alu_ctrl_o),
        .inst_reg_o         (inst)
    );

    ////////////////////////////////////////
    // Write path, loads advance one word per beat
    assign wr_width = wr_from_load ? vlane_seq_pkg::EW_WORD : inst.wdata_width;

    vrf_addr_counter u_wr_cnt (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .base_i  (cmd_i.waddr),         // Sampled on accept
        .width_i (wr_width),
        .load_i  (wr_load),
        .step_i  (wr_step),
        .addr_o  (vrf_wr_o.addr),
        .bwen_o  (wr_bwen)
    );

    // Same enable on all lanes unless a load beat supplies its own
    always_comb begin
        for (int i = 0; i < `VLANE_NUM; i++) begin
            vrf_wr_o.bwen[i] = wr_from_load ? load_i.bwen[i] : wr_bwen;
        end
    end

    ////////////////////////////////////////
    // Read ports
    for (genvar p = 0; p < `RD_PORTS; p++) begin : g_rd
        vrf_addr_counter u_rd_cnt (
            .clk_i   (clk_i),
            .rst_i   (rst_i),
            .base_i  (cmd_i.raddr[p]),
            .width_i (inst.vsew),
            .load_i  (rd_load),
            .step_i  (rd_step),
            .addr_o  (vrf_raddr_o[p]),
            .bwen_o  ()
        );
    end

    lane_valid_tracker u_valid (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .vl_i    (cmd_i.vl),
        .load_i  (valid_load),
        .shift_i (valid_shift),
        .valid_o (read_data_valid_o)
    );

endmodule

/* testbench/tb_vlane_seq.sv */
// Testbench for the vector lane sequencer
// Random commands and load beats from a fixed seed, cycle model of reads,
// writes, strobes and the command handshake, plus a run watchdog

`timescale 1ns/10ps

`include "vlane_seq_cfg.svh"

module tb_vlane_seq;

    localparam int CLK_PERIOD   = 10;
    localparam int NUM_CMDS     = 200;
    localparam int MAX_INST_CYC = 30;      // 6 beats with 3 stall cycles each, plus idle
    localparam int WATCHDOG_NS  = (NUM_CMDS + 4) * MAX_INST_CYC * CLK_PERIOD;

    logic                                       clk_i;
    logic                                       rst_i;
    vlane_seq_pkg::seq_cmd_t                    cmd_i;
    logic                                       cmd_valid_i;
    logic                                       cmd_ready_o;
    vlane_seq_pkg::load_beat_t                  load_i;
    logic                                       load_valid_i;
    logic                                       load_ready_o;
    logic                                       vrf_ren_o;
    vlane_seq_pkg::vrf_addr_t [`RD_PORTS-1:0]   vrf_raddr_o;
    vlane_seq_pkg::vrf_wr_t                     vrf_wr_o;
    logic                                       vrf_wen_o;
    vlane_seq_pkg::lane_mask_t                  read_data_valid_o;
    vlane_seq_pkg::step_t                       vmrf_addr_o;
    logic                                       vmrf_wen_o;
    logic                                       store_data_valid_o;
    logic                                       index_valid_o;
    vlane_seq_pkg::port_sel_t                   store_data_sel_o;
    vlane_seq_pkg::port_sel_t                   index_sel_o;
    vlane_seq_pkg::alu_ctrl_t                   alu_ctrl_o;

    int checks = 0;
    int errors = 0;

    vlane_seq_top UUT (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    ////////////////////////////////////////
    // Reference model
    function automatic int elems_per_word(input vlane_seq_pkg::elem_width_e w);
        case (w)
            vlane_seq_pkg::EW_BYTE: return 4;
            vlane_seq_pkg::EW_HALF: return 2;
            default:                return 1;
        endcase
    endfunction

    function automatic vlane_seq_pkg::bwen_t elem_bwen(input vlane_seq_pkg::elem_width_e w,
                                                       input int j);
        case (w)
            vlane_seq_pkg::EW_BYTE: return 4'b0001 << (j % 4);
            vlane_seq_pkg::EW_HALF: return (j % 2) ? 4'b1100 : 4'b0011;
            default:                return 4'b1111;
        endcase
    endfunction

    // Lane i of row k holds element k*8+i
    function automatic vlane_seq_pkg::lane_mask_t lane_mask(input int vl, input int k);
        vlane_seq_pkg::lane_mask_t m;
        for (int i = 0; i < `VLANE_NUM; i++) begin
            m[i] = (k * `VLANE_NUM + i) < vl;
        end
        return m;
    endfunction

    function automatic vlane_seq_pkg::seq_cmd_t random_cmd();
        vlane_seq_pkg::seq_cmd_t c;
        logic [63:0] r;
        c = '0;
        case ($urandom_range(0, 5))
            0, 1:    c.inst_type = vlane_seq_pkg::NORMAL;   // Twice as likely
            2:       c.inst_type = vlane_seq_pkg::STORE;
            3:       c.inst_type = vlane_seq_pkg::INDEXED_STORE;
            4:       c.inst_type = vlane_seq_pkg::LOAD;
            default: c.inst_type = vlane_seq_pkg::INDEXED_LOAD;
        endcase
        c.vl          = $urandom_range(1, 64);
        c.inst_delay  = $urandom_range(0, 7);
        c.vsew        = vlane_seq_pkg::elem_width_e'($urandom_range(1, 3));
        c.wdata_width = vlane_seq_pkg::elem_width_e'($urandom_range(1, 3));
        c.waddr       = $urandom;
        for (int p = 0; p < `RD_PORTS; p++) begin
            c.raddr[p] = $urandom;
        end
        c.store_data_sel = $urandom;
        c.index_sel      = $urandom;
        r     = {$urandom, $urandom};
        c.alu = r[$bits(vlane_seq_pkg::alu_ctrl_t)-1:0];
        return c;
    endfunction

    ////////////////////////////////////////
    // Checks
    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_idle();
        check_val("cmd_ready_o", cmd_ready_o, 1);
        check_val("vrf_ren_o", vrf_ren_o, 0);
        check_val("vrf_wen_o", vrf_wen_o, 0);
        check_val("load_ready_o", load_ready_o, 0);
        check_val("store_data_valid_o", store_data_valid_o, 0);
        check_val("index_valid_o", index_valid_o, 0);
        check_val("vmrf_wen_o", vmrf_wen_o, 0);
        check_val("read_data_valid_o", read_data_valid_o, 0);
    endtask

    // Fields held for the whole instruction
    task automatic check_common(input vlane_seq_pkg::seq_cmd_t c);
        check_val("cmd_ready_o", cmd_ready_o, 0);
        check_val("store_data_sel_o", store_data_sel_o, c.store_data_sel);
        check_val("index_sel_o", index_sel_o, c.index_sel);
        check_val("alu_ctrl_o", alu_ctrl_o, c.alu);
    endtask

    ////////////////////////////////////////
    // Read driven instructions, next command may be held early
    task automatic run_reads(input vlane_seq_pkg::seq_cmd_t c, input vlane_seq_pkg::seq_cmd_t nxt);
        int  rl;
        int  total;
        int  hold_at;
        int  rd_seen;
        int  j;
        bit  is_normal;
        bit  is_store;
        bit  is_index;
        bit  held;
        rl        = (int'(c.vl) + `VLANE_NUM - 1) / `VLANE_NUM;
        is_normal = (c.inst_type == vlane_seq_pkg::NORMAL);
        is_store  = (c.inst_type == vlane_seq_pkg::STORE)
                 || (c.inst_type == vlane_seq_pkg::INDEXED_STORE);
        is_index  = (c.inst_type == vlane_seq_pkg::INDEXED_STORE)
                 || (c.inst_type == vlane_seq_pkg::INDEXED_LOAD);
        total     = is_normal ? rl + int'(c.inst_delay) : rl;
        hold_at   = $urandom_range(0, total + 1);     // Past the end means no early hold
        rd_seen   = 0;
        held      = 0;
        for (int cyc = 0; cyc < total; cyc++) begin
            if (cyc == hold_at) begin
                cmd_i       = nxt;
                cmd_valid_i = 1;
                held        = 1;
            end
            @(negedge clk_i);
            check_common(c);
            check_val("vrf_ren_o", vrf_ren_o, cyc < rl);
            if (vrf_ren_o) rd_seen++;
            if (cyc < rl) begin
                for (int p = 0; p < `RD_PORTS; p++) begin
                    check_val("vrf_raddr_o", vrf_raddr_o[p],
                              vlane_seq_pkg::vrf_addr_t'(c.raddr[p] + cyc / elems_per_word(c.vsew)));
                end
            end
            check_val("read_data_valid_o", read_data_valid_o,
                      (cyc < rl) ? lane_mask(c.vl, cyc) : '0);
            check_val("store_data_valid_o", store_data_valid_o, (cyc < rl) && is_store);
            check_val("index_valid_o", index_valid_o, (cyc < rl) && is_index);
            j = cyc - int'(c.inst_delay);                 // Write index, delayed reads
            check_val("vrf_wen_o", vrf_wen_o, is_normal && j >= 0);
            if (is_normal && j >= 0) begin
                check_val("vrf_wr_o.addr", vrf_wr_o.addr,
                          vlane_seq_pkg::vrf_addr_t'(c.waddr + j / elems_per_word(c.wdata_width)));
                check_val("vrf_wr_o.bwen", vrf_wr_o.bwen, {`VLANE_NUM{elem_bwen(c.wdata_width, j)}});
                check_val("vmrf_addr_o", vmrf_addr_o, j);
                check_val("vmrf_wen_o", vmrf_wen_o, c.alu.vector_mask);
            end else begin
                check_val("vmrf_wen_o", vmrf_wen_o, 0);
            end
            @(posedge clk_i);
            #1;
        end
        check_val("read cycle count", rd_seen, rl);
        if (!held) begin
            cmd_i       = nxt;
            cmd_valid_i = 1;
        end
    endtask

    ////////////////////////////////////////
    // Unit load, random stalls between beats
    task automatic run_load(input vlane_seq_pkg::seq_cmd_t c, input vlane_seq_pkg::seq_cmd_t nxt);
        int nbeats;
        int beat;
        int stall;
        nbeats = $urandom_range(1, 6);
        beat   = 0;
        while (beat < nbeats) begin
            stall = $urandom_range(0, 3);
            for (int s = 0; s <= stall; s++) begin
                load_valid_i = (s == stall);
                load_i.bwen  = $urandom;
                load_i.last  = (beat == nbeats - 1);
                @(negedge clk_i);
                check_common(c);
                check_val("load_ready_o", load_ready_o, 1);
                check_val("vrf_ren_o", vrf_ren_o, 0);
                check_val("vrf_wen_o", vrf_wen_o, load_valid_i);
                if (load_valid_i) begin
                    check_val("vrf_wr_o.addr", vrf_wr_o.addr,
                              vlane_seq_pkg::vrf_addr_t'(c.waddr + beat));
                    check_val("vrf_wr_o.bwen", vrf_wr_o.bwen, load_i.bwen);
                    check_val("vmrf_addr_o", vmrf_addr_o, beat);
                    check_val("vmrf_wen_o", vmrf_wen_o, c.alu.vector_mask);
                end
                @(posedge clk_i);
                #1;
            end
            beat++;
        end
        load_valid_i = 0;
        cmd_i        = nxt;
        cmd_valid_i  = 1;
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        int unsigned             seed_val;
        vlane_seq_pkg::seq_cmd_t cur;
        vlane_seq_pkg::seq_cmd_t nxt;
        seed_val     = $urandom(32'he4fe_b251);
        clk_i        = 0;
        rst_i        = 0;
        cmd_i        = '0;
        cmd_valid_i  = 0;
        load_i       = '0;
        load_valid_i = 0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_i       = 1;
        nxt         = random_cmd();
        cmd_i       = nxt;
        cmd_valid_i = 1;
        for (int n = 0; n < NUM_CMDS; n++) begin
            cur = nxt;
            nxt = random_cmd();
            @(negedge clk_i);
            check_idle();                       // Ready again, accept at this edge
            @(posedge clk_i);
            #1;
            cmd_valid_i = 0;
            if (cur.inst_type == vlane_seq_pkg::LOAD) begin
                run_load(cur, nxt);
            end else begin
                run_reads(cur, nxt);
            end
        end
        @(negedge clk_i);
        check_idle();
        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks run %0d, errors %0d", checks, errors);
        $display("Checks failed");
        $finish;
    end

endmodule

/* vlane_seq_top.f */
+incdir+include
hw/vlane_seq_pkg.sv
hw/vrf_addr_counter.sv
hw/lane_valid_tracker.sv
hw/lane_seq_fsm.sv
hw/vlane_seq_top.sv
testbench/tb_vlane_seq.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_vlane_seq
FILELIST  := vlane_seq_top.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := All checks passed
SOURCES   := $(shell grep -v '^+' $(FILELIST)) include/vlane_seq_cfg.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
